// ==== design/ascon_pkg.sv ====
package ascon_pkg;

    localparam int WORD_W = 16;
    localparam int RATE_W = 64;
    localparam int STATE_W = 320;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int PERM_ROUNDS = 12;
    localparam int IN_DEPTH = 4;
    localparam int HASH_OUT_BITS = 256;
    localparam int LEN_W = 32;
    localparam int RND_W = $clog2(PERM_ROUNDS);
    localparam int IN_PTR_W = $clog2(IN_DEPTH);
    localparam int IN_CNT_W = $clog2(IN_DEPTH + 1);
    localparam int TX_CREDIT_W = 8;

    // Precomputed initial states, x0 in the top 64 bits
    localparam logic [STATE_W-1:0] HASH_IV =
        320'hee9398aadb67f03d8bb21831c60f1002b48a92db98d5da6243189921b8f8e3e8348fa5c9d525e140;
    localparam logic [STATE_W-1:0] XOF_IV =
        320'hb57e273b814cd4162b51042562ae242066a3a7768ddf22185aad0a7a8153650c4f3e0e32539493b6;

    localparam logic [0:PERM_ROUNDS-1][7:0] ROUND_CONST = {
        8'hf0, 8'he1, 8'hd2, 8'hc3, 8'hb4, 8'ha5,
        8'h96, 8'h87, 8'h78, 8'h69, 8'h5a, 8'h4b
    };

    typedef enum logic [3:0] {
        CONF  = 4'h1,
        LEN   = 4'h2,
        MSG   = 4'h3,
        HASH  = 4'h4,
        ABORT = 4'h5
    } word_type_t;

    typedef struct packed {
        logic [WORD_W-2:0] rsvd;
        logic              xof;
    } conf_fields_t;

    // A data word, or the same bits seen as a config word
    typedef union packed {
        logic [WORD_W-1:0] raw;
        conf_fields_t      conf;
    } in_word_u;

    typedef struct packed {
        in_word_u   word;
        word_type_t kind;
        logic       last;
    } in_beat_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        word_type_t        kind;
        logic              last;
    } out_beat_t;

    // fin_words is 0 for a full block, else the word count of the final block
    typedef struct packed {
        logic [RATE_W-1:0] block;
        word_type_t        kind;
        logic [2:0]        fin_words;
    } squeeze_t;

endpackage

// ==== design/block_rx.sv ====
module block_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  ascon_pkg::in_beat_t in_beat,
    output logic                in_credit,
    output ascon_pkg::in_beat_t head,
    output logic                head_valid,
    input  logic                pop
);
    import ascon_pkg::*;

    in_beat_t              mem [IN_DEPTH];
    logic [IN_PTR_W-1:0]   wr_ptr;
    logic [IN_PTR_W-1:0]   rd_ptr;
    logic [IN_CNT_W-1:0]   count;
    logic                  do_pop;

    // The host's credits keep the FIFO from overflowing
    assign do_pop = pop && head_valid;
    assign head = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= do_pop;
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + IN_CNT_W'(in_valid) - IN_CNT_W'(do_pop);
        end
    end

endmodule

// ==== design/hash_config_regs.sv ====
module hash_config_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_conf,
    input  ascon_pkg::conf_fields_t     conf,
    input  logic                        load_len,
    input  logic [ascon_pkg::WORD_W-1:0] len_word,
    input  logic                        consume,
    output logic                        xof,
    output logic                        len_zero,
    output logic                        last_chunk,
    output logic [2:0]                  last_words
);
    import ascon_pkg::*;

    logic [LEN_W-1:0] remain;

    assign len_zero = (remain == '0);
    assign last_chunk = (remain <= LEN_W'(RATE_W));
    // Words left in a block of at most 64 bits
    assign last_words = (remain[5:4] == 2'd0) ? 3'd4 : {1'b0, remain[5:4]};

    always_ff @(posedge clk) begin
        if (!rst) begin
            xof <= 1'b0;
            remain <= '0;
        end else if (load_conf) begin
            xof <= conf.xof;
            remain <= conf.xof ? '0 : LEN_W'(HASH_OUT_BITS);
        end else if (load_len) begin
            remain <= {remain[LEN_W-WORD_W-1:0], len_word};
        end else if (consume) begin
            remain <= last_chunk ? '0 : remain - LEN_W'(RATE_W);
        end
    end

endmodule

// ==== design/hash_control.sv ====
module hash_control (
    input  logic                          clk,
    input  logic                          rst,
    input  ascon_pkg::in_beat_t           head,
    input  logic                          head_valid,
    output logic                          pop,
    output logic                          load_conf,
    output ascon_pkg::conf_fields_t       conf,
    output logic                          load_len,
    output logic [ascon_pkg::WORD_W-1:0]  len_word,
    output logic                          consume,
    input  logic                          xof,
    input  logic                          len_zero,
    input  logic                          last_chunk,
    input  logic [2:0]                    last_words,
    output logic                          perm_start,
    output logic [ascon_pkg::STATE_W-1:0] perm_state_in,
    input  logic                          perm_done,
    input  logic [ascon_pkg::STATE_W-1:0] perm_state_out,
    output logic                          tx_load,
    output ascon_pkg::squeeze_t           tx_blk,
    input  logic                          tx_idle
);
    import ascon_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_INIT, S_LEN, S_ABSORB, S_ABS_START, S_ABS_WAIT,
        S_SQUEEZE, S_SQZ_START, S_SQZ_WAIT, S_ABORT
    } fsm_t;

    fsm_t               fsm;
    logic [STATE_W-1:0] st;
    logic [RATE_W-1:0]  acc;
    logic [1:0]         wcnt;
    logic               lcnt;
    logic               fin;
    logic               take;

    assign take = head_valid && (fsm == S_IDLE || fsm == S_LEN || fsm == S_ABSORB);
    assign pop = take;

    assign conf = head.word.conf;
    assign len_word = head.word.raw;
    assign load_conf = take && fsm == S_IDLE && head.kind == CONF;
    assign load_len = take && fsm == S_LEN && head.kind == LEN;

    assign perm_start = (fsm == S_ABS_START) || (fsm == S_SQZ_START);
    // Message block goes into the x0 lane
    assign perm_state_in = (fsm == S_ABS_START) ?
        {st[STATE_W-1 -: RATE_W] ^ acc, st[STATE_W-RATE_W-1:0]} : st;

    assign tx_load = tx_idle && ((fsm == S_SQUEEZE && !len_zero) || fsm == S_ABORT);
    assign consume = tx_load && fsm == S_SQUEEZE;

    always_comb begin
        if (fsm == S_ABORT) begin
            tx_blk.block = '0;
            tx_blk.kind = ABORT;
            tx_blk.fin_words = 3'd1;
        end else begin
            tx_blk.block = st[STATE_W-1 -: RATE_W];
            tx_blk.kind = HASH;
            tx_blk.fin_words = last_chunk ? last_words : 3'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && fsm == S_ABSORB) begin
            acc <= {acc[RATE_W-WORD_W-1:0], head.word.raw};
        end
        if (fsm == S_INIT) begin
            st <= xof ? XOF_IV : HASH_IV;
        end else if (perm_done) begin
            st <= perm_state_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fsm <= S_IDLE;
            wcnt <= '0;
            lcnt <= 1'b0;
            fin <= 1'b0;
        end else begin
            case (fsm)
                S_IDLE: begin
                    if (take) begin
                        fsm <= (head.kind == CONF) ? S_INIT : S_ABORT;
                    end
                end
                S_INIT: begin
                    wcnt <= '0;
                    lcnt <= 1'b0;
                    fsm <= xof ? S_LEN : S_ABSORB;
                end
                S_LEN: begin
                    if (take) begin
                        lcnt <= 1'b1;
                        if (head.kind != LEN) begin
                            fsm <= S_ABORT;
                        end else if (lcnt) begin
                            fsm <= S_ABSORB;
                        end
                    end
                end
                S_ABSORB: begin
                    if (take) begin
                        wcnt <= wcnt + 1'b1;
                        fin <= head.last;
                        if (head.kind != MSG || (head.last && wcnt != 2'd3)) begin
                            fsm <= S_ABORT;
                        end else if (wcnt == 2'd3) begin
                            fsm <= S_ABS_START;
                        end
                    end
                end
                S_ABS_START: fsm <= S_ABS_WAIT;
                S_ABS_WAIT: begin
                    if (perm_done) begin
                        fsm <= fin ? S_SQUEEZE : S_ABSORB;
                    end
                end
                S_SQUEEZE: begin
                    // Zero-length output ends the job with nothing sent
                    if (len_zero) begin
                        fsm <= S_IDLE;
                    end else if (tx_load) begin
                        fsm <= last_chunk ? S_IDLE : S_SQZ_START;
                    end
                end
                S_SQZ_START: fsm <= S_SQZ_WAIT;
                S_SQZ_WAIT: begin
                    if (perm_done) begin
                        fsm <= S_SQUEEZE;
                    end
                end
                S_ABORT: begin
                    if (tx_load) begin
                        fsm <= S_IDLE;
                    end
                end
                default: fsm <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== design/ascon_permutation.sv ====
module ascon_permutation (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [ascon_pkg::STATE_W-1:0] state_in,
    output logic                          done,
    output logic [ascon_pkg::STATE_W-1:0] state_out
);
    import ascon_pkg::*;

    logic [STATE_W-1:0] state;
    logic [RND_W-1:0]   rnd;
    logic               busy;

    function automatic logic [63:0] ror(input logic [63:0] x, input int n);
        return (x >> n) | (x << (64 - n));
    endfunction

    function automatic logic [STATE_W-1:0] perm_round(input logic [STATE_W-1:0] s,
                                                      input logic [7:0] rc);
        logic [63:0] x0, x1, x2, x3, x4;
        logic [63:0] t0, t1, t2, t3, t4;
        {x0, x1, x2, x3, x4} = s;
        x2 = x2 ^ {56'd0, rc};
        // S-box layer, bit-sliced over the five lanes
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 = x0 ^ t1;
        x1 = x1 ^ t2;
        x2 = x2 ^ t3;
        x3 = x3 ^ t4;
        x4 = x4 ^ t0;
        x1 = x1 ^ x0;
        x0 = x0 ^ x4;
        x3 = x3 ^ x2;
        x2 = ~x2;
        // Linear diffusion
        x0 = x0 ^ ror(x0, 19) ^ ror(x0, 28);
        x1 = x1 ^ ror(x1, 61) ^ ror(x1, 39);
        x2 = x2 ^ ror(x2, 1) ^ ror(x2, 6);
        x3 = x3 ^ ror(x3, 10) ^ ror(x3, 17);
        x4 = x4 ^ ror(x4, 7) ^ ror(x4, 41);
        return {x0, x1, x2, x3, x4};
    endfunction

    assign state_out = state;

    // Round 0 is applied on the start edge
    always_ff @(posedge clk) begin
        if (start) begin
            state <= perm_round(state_in, ROUND_CONST[0]);
        end else if (busy) begin
            state <= perm_round(state, ROUND_CONST[rnd]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            rnd <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                rnd <= RND_W'(1);
            end else if (busy) begin
                rnd <= rnd + 1'b1;
                if (rnd == RND_W'(PERM_ROUNDS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/block_tx.sv ====
module block_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  ascon_pkg::squeeze_t  blk,
    output logic                 idle,
    input  logic                 out_credit,
    output logic                 out_valid,
    output ascon_pkg::out_beat_t out_beat
);
    import ascon_pkg::*;

    logic [RATE_W-1:0]      shreg;
    word_type_t             kind_q;
    logic                   fin_q;
    logic [2:0]             left;
    logic [TX_CREDIT_W-1:0] credits;
    logic                   emit;
    logic                   is_abort;

    assign idle = (left == 3'd0);
    assign emit = !idle && (credits != '0);
    assign is_abort = (blk.kind == ABORT);

    always_ff @(posedge clk) begin
        if (load && idle) begin
            shreg <= is_abort ? '0 : blk.block;
            kind_q <= blk.kind;
            fin_q <= is_abort || (blk.fin_words != 3'd0);
        end else if (emit) begin
            shreg <= shreg << WORD_W;
        end
        if (emit) begin
            out_beat.data <= shreg[RATE_W-1 -: WORD_W];
            out_beat.kind <= kind_q;
            out_beat.last <= fin_q && (left == 3'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            left <= 3'd0;
            credits <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit;
            credits <= credits + TX_CREDIT_W'(out_credit) - TX_CREDIT_W'(emit);
            if (load && idle) begin
                if (is_abort) begin
                    left <= 3'd1;
                end else if (blk.fin_words == 3'd0) begin
                    left <= 3'(WORDS_PER_BLOCK);
                end else begin
                    left <= blk.fin_words;
                end
            end else if (emit) begin
                left <= left - 3'd1;
            end
        end
    end

endmodule

// ==== design/ascon_hash_top.sv ====
module ascon_hash_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  ascon_pkg::in_beat_t  in_beat,
    output logic                 in_credit,
    input  logic                 out_credit,
    output logic                 out_valid,
    output ascon_pkg::out_beat_t out_beat
);
    import ascon_pkg::*;

    in_beat_t          head;
    logic              head_valid;
    logic              pop;
    logic              load_conf;
    conf_fields_t      conf;
    logic              load_len;
    logic [WORD_W-1:0] len_word;
    logic              consume;
    logic              xof;
    logic              len_zero;
    logic              last_chunk;
    logic [2:0]        last_words;
    logic              perm_start;
    logic [STATE_W-1:0] perm_state_in;
    logic              perm_done;
    logic [STATE_W-1:0] perm_state_out;
    logic              tx_load;
    squeeze_t          tx_blk;
    logic              tx_idle;

    block_rx u_rx (
        .clk, .rst, .in_valid, .in_beat, .in_credit,
        .head, .head_valid, .pop
    );

    hash_control u_ctrl (
        .clk, .rst, .head, .head_valid, .pop,
        .load_conf, .conf, .load_len, .len_word, .consume,
        .xof, .len_zero, .last_chunk, .last_words,
        .perm_start, .perm_state_in, .perm_done, .perm_state_out,
        .tx_load, .tx_blk, .tx_idle
    );

    hash_config_regs u_cfg (
        .clk, .rst, .load_conf, .conf, .load_len, .len_word, .consume,
        .xof, .len_zero, .last_chunk, .last_words
    );

    ascon_permutation u_perm (
        .clk, .rst, .start(perm_start), .state_in(perm_state_in),
        .done(perm_done), .state_out(perm_state_out)
    );

    block_tx u_tx (
        .clk, .rst, .load(tx_load), .blk(tx_blk), .idle(tx_idle),
        .out_credit, .out_valid, .out_beat
    );

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk
);
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// ==== test/ascon_hash_assertions.sv ====
module ascon_hash_assertions (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_credit,
    input logic out_credit,
    input logic out_valid
);
    import ascon_pkg::*;

    logic [7:0] host_credits;
    logic [8:0] granted;

    // Host-side view of both credit loops
    always_ff @(posedge clk) begin
        if (!rst) begin
            host_credits <= 8'(IN_DEPTH);
            granted <= '0;
        end else begin
            host_credits <= host_credits + 8'(in_credit) - 8'(in_valid);
            granted <= granted + 9'(out_credit) - 9'(out_valid);
        end
    end

    credit_return_bounded: assert property (@(posedge clk) disable iff (!rst)
        in_credit |-> host_credits < 8'(IN_DEPTH))
        else $error("input credit returned beyond the FIFO depth");

    output_within_grants: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> granted != '0)
        else $error("output word sent without a granted credit");

    quiet_in_reset: assert property (@(posedge clk)
        (!rst && $past(!rst)) |-> !out_valid)
        else $error("output valid while reset is active");

endmodule

bind ascon_hash_top ascon_hash_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_credit(in_credit),
    .out_credit(out_credit),
    .out_valid(out_valid)
);

// ==== test/ascon_model.svh ====
`ifndef ASCON_MODEL_SVH
`define ASCON_MODEL_SVH

typedef logic [15:0] word_q_t[$];
typedef logic [63:0] block_q_t[$];

// 5-bit S-box, input and output read with x0 as the MSB
localparam logic [4:0] SBOX [32] = '{
    5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
    5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
    5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
    5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17
};

function automatic logic [63:0] rotr(input logic [63:0] v, input int k);
    logic [127:0] d;
    d = {v, v} >> k;
    return d[63:0];
endfunction

function automatic logic [319:0] ascon_round(input logic [319:0] s, input int r);
    logic [63:0] x [5];
    logic [4:0]  col;
    for (int i = 0; i < 5; i++) begin
        x[i] = s[319 - 64 * i -: 64];
    end
    x[2][7:0] = x[2][7:0] ^ {4'(15 - r), 4'(r)};
    for (int b = 0; b < 64; b++) begin
        col = SBOX[{x[0][b], x[1][b], x[2][b], x[3][b], x[4][b]}];
        {x[0][b], x[1][b], x[2][b], x[3][b], x[4][b]} = col;
    end
    x[0] = x[0] ^ rotr(x[0], 19) ^ rotr(x[0], 28);
    x[1] = x[1] ^ rotr(x[1], 61) ^ rotr(x[1], 39);
    x[2] = x[2] ^ rotr(x[2], 1) ^ rotr(x[2], 6);
    x[3] = x[3] ^ rotr(x[3], 10) ^ rotr(x[3], 17);
    x[4] = x[4] ^ rotr(x[4], 7) ^ rotr(x[4], 41);
    return {x[0], x[1], x[2], x[3], x[4]};
endfunction

function automatic logic [319:0] permute12(input logic [319:0] s);
    for (int r = 0; r < 12; r++) begin
        s = ascon_round(s, r);
    end
    return s;
endfunction

// Absorb padded blocks into x0, then squeeze out_bits of output
function automatic word_q_t sponge_words(input bit is_xof, input block_q_t msg,
                                         input int out_bits);
    logic [319:0] s;
    word_q_t      w;
    int           left;
    int           n;
    s = is_xof ? XOF_IV : HASH_IV;
    foreach (msg[i]) begin
        s[319:256] = s[319:256] ^ msg[i];
        s = permute12(s);
    end
    left = out_bits;
    while (left > 0) begin
        n = (left >= 64) ? 4 : left / 16;
        for (int k = 0; k < n; k++) begin
            w.push_back(s[319 - 16 * k -: 16]);
        end
        left = left - 64;
        if (left > 0) begin
            s = permute12(s);
        end
    end
    return w;
endfunction

`endif

// ==== test/tb_ascon_hash.sv ====
module tb_ascon_hash;
    import ascon_pkg::*;

    localparam int     DRIVE_DLY = 10;
    localparam int     PERIOD = 100;
    localparam int     NUM_JOBS = 24;
    localparam int     MAX_BLOCKS = 16;
    localparam int     BLOCK_CYCLES = 400;
    localparam longint TIMEOUT = longint'(NUM_JOBS) * MAX_BLOCKS * BLOCK_CYCLES * PERIOD;
    localparam int     GRANT_LIMIT = 12;

    logic      clk;
    logic      rst;
    logic      in_valid;
    in_beat_t  in_beat;
    logic      in_credit;
    logic      out_credit;
    logic      out_valid;
    out_beat_t out_beat;

    integer    seed;
    integer    grant_seed;
    int        in_credits;
    int        out_owed;
    int        stall_left;
    bit        backpressure;
    int        errors;
    int        test_errors;
    int        tests_run;
    int        tests_failed;
    out_beat_t got_q[$];

    `include "ascon_model.svh"

    tb_clock_gen u_clk (.clk(clk));

    ascon_hash_top DUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_beat(in_beat),
        .in_credit(in_credit), .out_credit(out_credit),
        .out_valid(out_valid), .out_beat(out_beat)
    );

    // Monitor for returned input credits and output words
    always @(negedge clk) begin
        if (in_credit) begin
            in_credits++;
        end
        if (out_valid) begin
            got_q.push_back(out_beat);
            out_owed--;
        end
    end

    initial begin
        wait (rst === 1'b1);
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            out_credit = 1'b0;
            if (stall_left > 0) begin
                stall_left--;
            end else if (backpressure && ($random(grant_seed) & 15) == 0) begin
                stall_left = $unsigned($random(grant_seed)) % 40;
            end else if (out_owed < GRANT_LIMIT && ($random(grant_seed) & 3) != 0) begin
                out_credit = 1'b1;
                out_owed++;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired: the DUT stopped producing output before the tests ended");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %0h expected %0h", $time, msg, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic align_drive();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Entered and left a drive delay after a rising edge
    task automatic send_beat(input word_type_t kind, input logic [15:0] data, input logic last);
        while (in_credits == 0) begin
            align_drive();
        end
        in_valid = 1'b1;
        in_beat.word.raw = data;
        in_beat.kind = kind;
        in_beat.last = last;
        in_credits--;
        align_drive();
        in_valid = 1'b0;
    endtask

    task automatic collect_words(input word_q_t exp, input word_type_t kind, input string what);
        out_beat_t b;
        while (got_q.size() < exp.size()) begin
            @(negedge clk);
        end
        foreach (exp[i]) begin
            b = got_q.pop_front();
            check_value(64'(b.data), 64'(exp[i]), $sformatf("%s word %0d data", what, i));
            check_value(64'(b.kind), 64'(kind), $sformatf("%s word %0d kind", what, i));
            check_value(64'(b.last), 64'(i == exp.size() - 1),
                        $sformatf("%s word %0d last", what, i));
        end
        check_value(64'(in_credits), 64'(IN_DEPTH), {what, " input credits back"});
        align_drive();
    endtask

    task automatic run_job(input bit is_xof, input int nblocks, input int out_bits,
                           input string what);
        block_q_t    blocks;
        word_q_t     exp;
        in_word_u    cw;
        logic [31:0] len_bits;
        logic [31:0] hi;
        logic [31:0] lo;
        len_bits = out_bits;
        for (int i = 0; i < nblocks; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            blocks.push_back({hi, lo});
        end
        exp = sponge_words(is_xof, blocks, out_bits);
        cw.raw = '0;
        cw.conf.xof = is_xof;
        send_beat(CONF, cw.raw, 1'b1);
        if (is_xof) begin
            send_beat(LEN, len_bits[31:16], 1'b0);
            send_beat(LEN, len_bits[15:0], 1'b1);
        end
        foreach (blocks[b]) begin
            for (int k = 0; k < 4; k++) begin
                send_beat(MSG, blocks[b][63 - 16 * k -: 16], b == nblocks - 1 && k == 3);
            end
        end
        collect_words(exp, HASH, what);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %-22s %s", tests_run, name, (test_errors == 0) ? "ok" : "failed");
        test_errors = 0;
    endtask

    initial begin
        word_q_t abort_word;
        seed = 32'h8b695db6;
        grant_seed = ~seed;
        rst = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        out_credit = 1'b0;
        in_credits = IN_DEPTH;
        out_owed = 0;
        stall_left = 0;
        backpressure = 1'b0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        abort_word.push_back(16'h0000);
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        align_drive();

        for (int j = 0; j < 6; j++) begin
            run_job(1'b0, 1 + $unsigned($random(seed)) % 6, HASH_OUT_BITS, "hash");
        end
        end_test("hash random messages");

        for (int j = 0; j < 6; j++) begin
            run_job(1'b1, 1 + $unsigned($random(seed)) % 6,
                    16 * (1 + $unsigned($random(seed)) % 32), "xof");
        end
        end_test("xof random lengths");

        backpressure = 1'b1;
        for (int j = 0; j < 4; j++) begin
            run_job(j[0], 1 + $unsigned($random(seed)) % 6,
                    j[0] ? 16 * (1 + $unsigned($random(seed)) % 32) : HASH_OUT_BITS,
                    "backpressure");
        end
        backpressure = 1'b0;
        end_test("output backpressure");

        // Long messages keep the input FIFO full for many cycles
        for (int j = 0; j < 3; j++) begin
            run_job(1'b0, 6, HASH_OUT_BITS, "input flow");
        end
        end_test("input flow control");

        send_beat(MSG, 16'($random(seed)), 1'b0);
        collect_words(abort_word, ABORT, "abort on msg");
        run_job(1'b0, 2, HASH_OUT_BITS, "hash after abort");
        end_test("abort msg before conf");

        send_beat(CONF, 16'h0000, 1'b1);
        send_beat(LEN, 16'($random(seed)), 1'b0);
        collect_words(abort_word, ABORT, "abort on len");
        run_job(1'b0, 3, HASH_OUT_BITS, "hash after abort");
        repeat (64) @(posedge clk);
        check_value(64'(got_q.size()), 64'd0, "extra output words");
        end_test("abort len in hash");

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
design/ascon_pkg.sv
design/block_rx.sv
design/hash_config_regs.sv
design/hash_control.sv
design/ascon_permutation.sv
design/block_tx.sv
design/ascon_hash_top.sv
test/tb_clock_gen.sv
test/ascon_hash_assertions.sv
test/tb_ascon_hash.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ascon_hash -f vlog.f
./obj_dir/Vtb_ascon_hash | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
